//--- compile.f
hw/pwo_pkg.sv
hw/pwo_ctrl.sv
hw/pwo_operand_buffer.sv
hw/pwo_unit.sv
hw/pwo_top.sv
tb/pwo_mem_model.sv
tb/pwo_checker.sv
tb/tb_pwo_top.sv

//--- hw/pwo_ctrl.sv
// Pointwise controller: FSM, read address sequencing, write delay line, busy and done
`timescale 1ns/1ps

module pwo_ctrl
    import pwo_pkg::*;
(
    input  logic          clk,
    input  logic          reset_n,
    input  logic          zeroize,
    input  mode_t         mode,
    input  logic          accumulate,
    input  logic          pwo_enable,
    input  pwo_mem_addr_t pwo_mem_base_addr,

    output mem_if_t       pwm_a_rd_req_o,
    output mem_if_t       pwm_b_rd_req_o,
    output mem_if_t       mem_rd_req_o,
    output mem_if_t       mem_wr_req_o,
    output logic          rd_issued_o,
    output logic          pwo_busy_o,
    output logic          pwo_done_o
);

    ctrl_state_t               state;
    ctrl_state_t               state_nxt;
    logic [WORD_CNT_WIDTH-1:0] word_cnt;
    logic [MEM_ADDR_WIDTH-1:0] word_offset;
    logic                      start;
    logic                      reading;
    logic                      last_word;
    logic                      acc_rd;
    logic                      wr_pending;
    logic                      done_q;

    // Settings captured at start
    mode_t                     mode_q;
    logic                      accumulate_q;
    pwo_mem_addr_t             base_q;

    mem_if_t                   wr_req_nxt;
    mem_if_t                   wr_dly [WR_LATENCY];

    assign start       = (state == ctrl_idle) && pwo_enable;
    assign reading     = (state == ctrl_run);
    assign last_word   = (word_cnt == WORD_CNT_WIDTH'(POLY_WORDS - 1));
    assign acc_rd      = reading && (mode_q == pwm) && accumulate_q;
    assign word_offset = MEM_ADDR_WIDTH'(word_cnt);

    // ==========================================================
    // FSM
    // ==========================================================
    always_comb begin
        state_nxt = state;
        case (state)
            ctrl_idle: begin
                if (pwo_enable) begin
                    state_nxt = ctrl_run;
                end
            end
            ctrl_run: begin
                if (last_word) begin
                    state_nxt = ctrl_drain;
                end
            end
            ctrl_drain: begin
                // Only the final write left in the delay line
                if (!wr_pending) begin
                    state_nxt = ctrl_idle;
                end
            end
            default: state_nxt = ctrl_idle;
        endcase
    end

    always_comb begin
        wr_pending = 1'b0;
        for (int i = 0; i < WR_LATENCY - 1; i++) begin
            if (wr_dly[i].rd_wr_en == RW_WRITE) begin
                wr_pending = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state    <= ctrl_idle;
            word_cnt <= '0;
            done_q   <= 1'b0;
            for (int i = 0; i < WR_LATENCY; i++) begin
                wr_dly[i] <= '0;
            end
        end else if (zeroize) begin
            state    <= ctrl_idle;
            word_cnt <= '0;
            done_q   <= 1'b0;
            for (int i = 0; i < WR_LATENCY; i++) begin
                wr_dly[i] <= '0;
            end
        end else begin
            state  <= state_nxt;
            done_q <= (state == ctrl_drain) && !wr_pending;
            // Wraps back to zero after the last word
            if (reading) begin
                word_cnt <= word_cnt + 1'b1;
            end
            wr_dly[0] <= wr_req_nxt;
            for (int i = 1; i < WR_LATENCY; i++) begin
                wr_dly[i] <= wr_dly[i-1];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            mode_q       <= mode;
            accumulate_q <= accumulate;
            base_q       <= pwo_mem_base_addr;
        end
    end

    // ==========================================================
    // Memory requests
    // ==========================================================
    always_comb begin
        pwm_a_rd_req_o.rd_wr_en = reading ? RW_READ : RW_IDLE;
        pwm_a_rd_req_o.addr     = reading ? base_q.a + word_offset : '0;
        pwm_b_rd_req_o.rd_wr_en = reading ? RW_READ : RW_IDLE;
        pwm_b_rd_req_o.addr     = reading ? base_q.b + word_offset : '0;
        // C is read only for multiply-accumulate
        mem_rd_req_o.rd_wr_en   = acc_rd ? RW_READ : RW_IDLE;
        mem_rd_req_o.addr       = acc_rd ? base_q.c + word_offset : '0;
        wr_req_nxt.rd_wr_en     = reading ? RW_WRITE : RW_IDLE;
        wr_req_nxt.addr         = reading ? base_q.c + word_offset : '0;
    end

    assign mem_wr_req_o = wr_dly[WR_LATENCY-1];
    assign rd_issued_o  = reading;
    assign pwo_busy_o   = (state != ctrl_idle);
    assign pwo_done_o   = done_q;

endmodule

//--- hw/pwo_operand_buffer.sv
// Operand buffer: registers returned memory words and unpacks them into lanes
`timescale 1ns/1ps

module pwo_operand_buffer
    import pwo_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,
    input  mode_t                     mode,
    input  logic                      accumulate,
    input  logic                      rd_issued_i,
    input  logic [MEM_DATA_WIDTH-1:0] a_rd_data_i,
    input  logic [MEM_DATA_WIDTH-1:0] b_rd_data_i,
    input  logic [MEM_DATA_WIDTH-1:0] c_rd_data_i,

    output pwo_lanes_t                operands_o,
    output logic                      operands_valid_o
);

    logic                      rd_return_q;
    logic                      valid_q;
    logic                      use_w;
    logic [MEM_DATA_WIDTH-1:0] a_q;
    logic [MEM_DATA_WIDTH-1:0] b_q;
    logic [MEM_DATA_WIDTH-1:0] c_q;

    // Read data is on the ports one cycle after the request
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            rd_return_q <= 1'b0;
            valid_q     <= 1'b0;
        end else if (zeroize) begin
            rd_return_q <= 1'b0;
            valid_q     <= 1'b0;
        end else begin
            rd_return_q <= rd_issued_i;
            valid_q     <= rd_return_q;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_return_q) begin
            a_q <= a_rd_data_i;
            b_q <= b_rd_data_i;
            c_q <= c_rd_data_i;
        end
    end

    assign use_w = (mode == pwm) && accumulate;

    // Drop the pad bit on top of each 24-bit slot
    always_comb begin
        operands_o = '0;
        for (int i = 0; i < NUM_LANES; i++) begin
            operands_o.u[i] = a_q[i*REG_SIZE +: COEFF_WIDTH];
            operands_o.v[i] = b_q[i*REG_SIZE +: COEFF_WIDTH];
            if (use_w) begin
                operands_o.w[i] = c_q[i*REG_SIZE +: COEFF_WIDTH];
            end
        end
    end

    assign operands_valid_o = valid_q;

endmodule

//--- hw/pwo_pkg.sv
// Pointwise datapath sizes, modulus, mode and state enums, memory request and lane structs
package pwo_pkg;

    // ==========================================================
    // Sizes
    // ==========================================================
    localparam int REG_SIZE       = 24;
    localparam int COEFF_WIDTH    = REG_SIZE - 1;
    localparam int PROD_WIDTH     = 2 * COEFF_WIDTH;
    localparam int NUM_LANES      = 4;
    localparam int MEM_DATA_WIDTH = NUM_LANES * REG_SIZE;
    localparam int MEM_ADDR_WIDTH = 15;
    localparam int POLY_WORDS     = 64;
    localparam int WORD_CNT_WIDTH = $clog2(POLY_WORDS);

    // Read request to write strobe, in cycles
    localparam int WR_LATENCY     = 4;

    // q = 2^23 - 2^13 + 1
    localparam logic [COEFF_WIDTH-1:0] DILITHIUM_Q = 23'd8380417;

    // ==========================================================
    // Enums
    // ==========================================================
    typedef enum logic [1:0] {
        pwm = 2'd0,
        pwa = 2'd1,
        pws = 2'd2
    } mode_t;

    typedef enum logic [1:0] {
        ctrl_idle  = 2'd0,
        ctrl_run   = 2'd1,
        ctrl_drain = 2'd2
    } ctrl_state_t;

    typedef enum logic [1:0] {
        RW_IDLE  = 2'd0,
        RW_READ  = 2'd1,
        RW_WRITE = 2'd2
    } rw_t;

    // ==========================================================
    // Structs
    // ==========================================================
    typedef struct packed {
        rw_t                       rd_wr_en;
        logic [MEM_ADDR_WIDTH-1:0] addr;
    } mem_if_t;

    typedef struct packed {
        logic [MEM_ADDR_WIDTH-1:0] a;
        logic [MEM_ADDR_WIDTH-1:0] b;
        logic [MEM_ADDR_WIDTH-1:0] c;
    } pwo_mem_addr_t;

    // u and v are the operands, w the accumulate term
    typedef struct packed {
        logic [NUM_LANES-1:0][COEFF_WIDTH-1:0] u;
        logic [NUM_LANES-1:0][COEFF_WIDTH-1:0] v;
        logic [NUM_LANES-1:0][COEFF_WIDTH-1:0] w;
    } pwo_lanes_t;

    typedef struct packed {
        logic [NUM_LANES-1:0][COEFF_WIDTH-1:0] uv;
    } pwo_out_t;

endpackage

//--- hw/pwo_top.sv
// Pointwise datapath top: controller, operand buffer and pointwise unit on the memory ports
`timescale 1ns/1ps

module pwo_top
    import pwo_pkg::*;
(
    input  logic                      clk,
    input  logic                      reset_n,
    input  logic                      zeroize,

    input  mode_t                     mode,
    input  logic                      accumulate,
    input  logic                      pwo_enable,
    input  pwo_mem_addr_t             pwo_mem_base_addr,

    // Operand memories A and B
    output mem_if_t                   pwm_a_rd_req_o,
    output mem_if_t                   pwm_b_rd_req_o,
    input  logic [MEM_DATA_WIDTH-1:0] pwm_a_rd_data_i,
    input  logic [MEM_DATA_WIDTH-1:0] pwm_b_rd_data_i,

    // Destination memory C
    output mem_if_t                   mem_rd_req_o,
    output mem_if_t                   mem_wr_req_o,
    output logic [MEM_DATA_WIDTH-1:0] mem_wr_data_o,
    input  logic [MEM_DATA_WIDTH-1:0] mem_rd_data_i,

    output logic                      pwo_busy_o,
    output logic                      pwo_done_o
);

    logic       rd_issued;
    logic       operands_valid;
    pwo_lanes_t operands;
    pwo_out_t   result;

    pwo_ctrl i_ctrl (
        .clk               (clk),
        .reset_n           (reset_n),
        .zeroize           (zeroize),
        .mode              (mode),
        .accumulate        (accumulate),
        .pwo_enable        (pwo_enable),
        .pwo_mem_base_addr (pwo_mem_base_addr),
        .pwm_a_rd_req_o    (pwm_a_rd_req_o),
        .pwm_b_rd_req_o    (pwm_b_rd_req_o),
        .mem_rd_req_o      (mem_rd_req_o),
        .mem_wr_req_o      (mem_wr_req_o),
        .rd_issued_o       (rd_issued),
        .pwo_busy_o        (pwo_busy_o),
        .pwo_done_o        (pwo_done_o)
    );

    pwo_operand_buffer i_operand_buffer (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize          (zeroize),
        .mode             (mode),
        .accumulate       (accumulate),
        .rd_issued_i      (rd_issued),
        .a_rd_data_i      (pwm_a_rd_data_i),
        .b_rd_data_i      (pwm_b_rd_data_i),
        .c_rd_data_i      (mem_rd_data_i),
        .operands_o       (operands),
        .operands_valid_o (operands_valid)
    );

    pwo_unit i_unit (
        .clk              (clk),
        .reset_n          (reset_n),
        .zeroize          (zeroize),
        .mode             (mode),
        .operands_i       (operands),
        .operands_valid_i (operands_valid),
        .result_o         (result)
    );

    // Zero pad bit above each lane
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            mem_wr_data_o[i*REG_SIZE +: REG_SIZE] = {1'b0, result.uv[i]};
        end
    end

endmodule

//--- hw/pwo_unit.sv
// Four-lane pointwise unit: modular add, subtract and multiply-accumulate, two stages
`timescale 1ns/1ps

module pwo_unit
    import pwo_pkg::*;
(
    input  logic       clk,
    input  logic       reset_n,
    input  logic       zeroize,
    input  mode_t      mode,
    input  pwo_lanes_t operands_i,
    input  logic       operands_valid_i,

    output pwo_out_t   result_o
);

    logic                                  s1_valid;
    mode_t                                 s1_mode;
    logic [NUM_LANES-1:0][PROD_WIDTH-1:0]  s1_val;
    logic [NUM_LANES-1:0][COEFF_WIDTH-1:0] s1_w;
    logic [NUM_LANES-1:0][COEFF_WIDTH-1:0] lane_res;
    pwo_out_t                              result_q;

    // Input below 2q
    function automatic logic [COEFF_WIDTH-1:0] cond_sub(input logic [REG_SIZE-1:0] x);
        logic [REG_SIZE-1:0] d;
        d = x - {1'b0, DILITHIUM_Q};
        return (x >= {1'b0, DILITHIUM_Q}) ? d[COEFF_WIDTH-1:0] : x[COEFF_WIDTH-1:0];
    endfunction

    function automatic logic [COEFF_WIDTH-1:0] add_mod(input logic [COEFF_WIDTH-1:0] a,
                                                      input logic [COEFF_WIDTH-1:0] b);
        return cond_sub({1'b0, a} + {1'b0, b});
    endfunction

    // Fold the top bits with 2^23 = 2^13 - 1 (mod q), three times
    function automatic logic [COEFF_WIDTH-1:0] mul_reduce(input logic [PROD_WIDTH-1:0] p);
        logic [36:0] f1;
        logic [27:0] f2;
        logic [23:0] f3;
        f1 = {1'b0, p[45:23], 13'h0} - {14'h0, p[45:23]} + {14'h0, p[22:0]};
        f2 = {1'b0, f1[36:23], 13'h0} - {14'h0, f1[36:23]} + {5'h0, f1[22:0]};
        // Now below 2q
        f3 = {6'h0, f2[27:23], 13'h0} - {19'h0, f2[27:23]} + {1'b0, f2[22:0]};
        return cond_sub(f3);
    endfunction

    // ==========================================================
    // Stage 1: sum, difference or product
    // ==========================================================
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            s1_valid <= 1'b0;
        end else if (zeroize) begin
            s1_valid <= 1'b0;
        end else begin
            s1_valid <= operands_valid_i;
        end
    end

    always_ff @(posedge clk) begin
        if (operands_valid_i) begin
            s1_mode <= mode;
            s1_w    <= operands_i.w;
            for (int i = 0; i < NUM_LANES; i++) begin
                case (mode)
                    pwm: begin
                        s1_val[i] <= PROD_WIDTH'(operands_i.u[i]) * PROD_WIDTH'(operands_i.v[i]);
                    end
                    pws: begin
                        // Offset by q keeps the difference positive
                        s1_val[i] <= PROD_WIDTH'({1'b0, operands_i.u[i]} +
                                                 {1'b0, DILITHIUM_Q} -
                                                 {1'b0, operands_i.v[i]});
                    end
                    default: begin
                        s1_val[i] <= PROD_WIDTH'({1'b0, operands_i.u[i]} +
                                                 {1'b0, operands_i.v[i]});
                    end
                endcase
            end
        end
    end

    // ==========================================================
    // Stage 2: reduction and accumulate
    // ==========================================================
    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (s1_mode == pwm) begin
                lane_res[i] = add_mod(mul_reduce(s1_val[i]), s1_w[i]);
            end else begin
                lane_res[i] = cond_sub(s1_val[i][REG_SIZE-1:0]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            result_q.uv <= lane_res;
        end
    end

    assign result_o = result_q;

endmodule

//--- run.sh
#!/bin/sh
# Build the pointwise datapath testbench with Verilator and run it.
# The exit status is that of the simulation.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
    -f compile.f \
    --top-module tb_pwo_top \
    -o sim_pwo && \
./obj_dir/sim_pwo +verilator+error+limit+100 || exit 1

//--- tb/pwo_checker.sv
// Bound checker for pwo_top covering write data, write address, requests and busy/done timing
`timescale 1ns/1ps

module pwo_checker
    import pwo_pkg::*;
(
    input logic                      clk,
    input logic                      reset_n,
    input logic                      zeroize,
    input mode_t                     mode,
    input logic                      accumulate,
    input logic                      pwo_enable,
    input pwo_mem_addr_t             pwo_mem_base_addr,
    input mem_if_t                   pwm_a_rd_req_o,
    input mem_if_t                   pwm_b_rd_req_o,
    input mem_if_t                   mem_rd_req_o,
    input mem_if_t                   mem_wr_req_o,
    input logic [MEM_DATA_WIDTH-1:0] mem_wr_data_o,
    input logic [MEM_DATA_WIDTH-1:0] pwm_a_rd_data_i,
    input logic [MEM_DATA_WIDTH-1:0] pwm_b_rd_data_i,
    input logic [MEM_DATA_WIDTH-1:0] mem_rd_data_i,
    input logic                      pwo_busy_o,
    input logic                      pwo_done_o
);

    int                        fail_count = 0;
    logic [7:0]                since_en;
    mode_t                     mode_q;
    logic                      acc_q;
    pwo_mem_addr_t             base_q;
    logic [MEM_DATA_WIDTH-1:0] exp_now;
    logic                      in_read;
    logic                      in_write;

    // Reference result for the words now on the read data ports
    function automatic logic [MEM_DATA_WIDTH-1:0] expect_word(
        input logic [MEM_DATA_WIDTH-1:0] a, input logic [MEM_DATA_WIDTH-1:0] b,
        input logic [MEM_DATA_WIDTH-1:0] c, input mode_t m, input logic acc);
        logic [MEM_DATA_WIDTH-1:0] w;
        longint                    x;
        longint                    y;
        longint                    z;
        longint                    q;
        longint                    r;
        w = '0;
        q = longint'(DILITHIUM_Q);
        for (int i = 0; i < NUM_LANES; i++) begin
            x = longint'(a[i*REG_SIZE +: COEFF_WIDTH]);
            y = longint'(b[i*REG_SIZE +: COEFF_WIDTH]);
            z = acc ? longint'(c[i*REG_SIZE +: COEFF_WIDTH]) : 0;
            case (m)
                pwa:     r = (x + y) % q;
                pws:     r = (x - y + q) % q;
                default: r = (x * y + z) % q;
            endcase
            w[i*REG_SIZE +: REG_SIZE] = REG_SIZE'(r);
        end
        return w;
    endfunction

    // Counts cycles from an accepted enable and sits at zero while idle
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            since_en <= '0;
        end else if (zeroize) begin
            since_en <= '0;
        end else if (pwo_enable && (since_en == 8'd0 || since_en == 8'd69)) begin
            since_en <= 8'd1;
            mode_q   <= mode;
            acc_q    <= accumulate;
            base_q   <= pwo_mem_base_addr;
        end else if (since_en == 8'd69) begin
            since_en <= '0;
        end else if (since_en != 8'd0) begin
            since_en <= since_en + 8'd1;
        end
    end

    assign in_read  = (since_en >= 8'd1) && (since_en <= 8'd64);
    assign in_write = (since_en >= 8'd5) && (since_en <= 8'd68);
    assign exp_now  = expect_word(pwm_a_rd_data_i, pwm_b_rd_data_i, mem_rd_data_i,
                                  mode_q, acc_q);

    // ==========================================================
    // Assertions
    // ==========================================================
    a_rd_seq: assert property (@(posedge clk) disable iff (!reset_n)
        in_read |-> (pwm_a_rd_req_o.rd_wr_en == RW_READ) &&
                    (pwm_a_rd_req_o.addr == base_q.a + MEM_ADDR_WIDTH'(since_en - 8'd1)) &&
                    (pwm_b_rd_req_o.rd_wr_en == RW_READ) &&
                    (pwm_b_rd_req_o.addr == base_q.b + MEM_ADDR_WIDTH'(since_en - 8'd1)))
        else begin
            fail_count++;
            $error("A/B read request out of sequence");
        end

    c_rd_sel: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_rd_req_o.rd_wr_en == RW_READ) == (in_read && mode_q == pwm && acc_q))
        else begin
            fail_count++;
            $error("C read request in wrong mode or cycle");
        end

    c_rd_addr: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_rd_req_o.rd_wr_en == RW_READ) |->
            (mem_rd_req_o.addr == base_q.c + MEM_ADDR_WIDTH'(since_en - 8'd1)))
        else begin
            fail_count++;
            $error("C read address mismatch");
        end

    wr_timing: assert property (@(posedge clk) disable iff (!reset_n)
        (mem_wr_req_o.rd_wr_en == RW_WRITE) == in_write)
        else begin
            fail_count++;
            $error("Write strobe not 4 cycles after read");
        end

    wr_addr: assert property (@(posedge clk) disable iff (!reset_n)
        in_write |-> mem_wr_req_o.addr == base_q.c + MEM_ADDR_WIDTH'(since_en - 8'd5))
        else begin
            fail_count++;
            $error("Write address mismatch");
        end

    wr_data: assert property (@(posedge clk) disable iff (!reset_n)
        in_write |-> mem_wr_data_o == $past(exp_now, 3))
        else begin
            fail_count++;
            $error("Write data mismatch");
        end

    busy_done: assert property (@(posedge clk) disable iff (!reset_n)
        (pwo_busy_o == (since_en >= 8'd1 && since_en <= 8'd68)) &&
        (pwo_done_o == (since_en == 8'd69)))
        else begin
            fail_count++;
            $error("Busy or done timing wrong");
        end

    idle_quiet: assert property (@(posedge clk) disable iff (!reset_n)
        (since_en == 8'd0) |-> (pwm_a_rd_req_o.rd_wr_en == RW_IDLE) &&
                               (pwm_b_rd_req_o.rd_wr_en == RW_IDLE) &&
                               (mem_rd_req_o.rd_wr_en == RW_IDLE) &&
                               (mem_wr_req_o.rd_wr_en == RW_IDLE))
        else begin
            fail_count++;
            $error("Request active while idle");
        end

endmodule

bind pwo_top pwo_checker i_checker (
    .clk               (clk),
    .reset_n           (reset_n),
    .zeroize           (zeroize),
    .mode              (mode),
    .accumulate        (accumulate),
    .pwo_enable        (pwo_enable),
    .pwo_mem_base_addr (pwo_mem_base_addr),
    .pwm_a_rd_req_o    (pwm_a_rd_req_o),
    .pwm_b_rd_req_o    (pwm_b_rd_req_o),
    .mem_rd_req_o      (mem_rd_req_o),
    .mem_wr_req_o      (mem_wr_req_o),
    .mem_wr_data_o     (mem_wr_data_o),
    .pwm_a_rd_data_i   (pwm_a_rd_data_i),
    .pwm_b_rd_data_i   (pwm_b_rd_data_i),
    .mem_rd_data_i     (mem_rd_data_i),
    .pwo_busy_o        (pwo_busy_o),
    .pwo_done_o        (pwo_done_o)
);

//--- tb/pwo_mem_model.sv
// Memory model: operand memories A and B and destination memory C, 1-cycle read latency
`timescale 1ns/1ps

module pwo_mem_model
    import pwo_pkg::*;
(
    input  logic                      clk,
    input  mem_if_t                   a_rd_req_i,
    input  mem_if_t                   b_rd_req_i,
    input  mem_if_t                   c_rd_req_i,
    input  mem_if_t                   c_wr_req_i,
    input  logic [MEM_DATA_WIDTH-1:0] c_wr_data_i,

    output logic [MEM_DATA_WIDTH-1:0] a_rd_data_o = '0,
    output logic [MEM_DATA_WIDTH-1:0] b_rd_data_o = '0,
    output logic [MEM_DATA_WIDTH-1:0] c_rd_data_o = '0
);

    logic [MEM_DATA_WIDTH-1:0] mem_a [POLY_WORDS];
    logic [MEM_DATA_WIDTH-1:0] mem_b [POLY_WORDS];
    logic [MEM_DATA_WIDTH-1:0] mem_c [POLY_WORDS];

    // Preload one word, sel 0 is A, 1 is B, 2 is C
    task automatic fill(input int sel, input int idx, input logic [MEM_DATA_WIDTH-1:0] data);
        case (sel)
            0: mem_a[idx] = data;
            1: mem_b[idx] = data;
            default: mem_c[idx] = data;
        endcase
    endtask

    // Bases are multiples of the poly size, so the low bits index the word
    always @(posedge clk) begin
        if (a_rd_req_i.rd_wr_en == RW_READ) begin
            a_rd_data_o <= mem_a[a_rd_req_i.addr[WORD_CNT_WIDTH-1:0]];
        end
        if (b_rd_req_i.rd_wr_en == RW_READ) begin
            b_rd_data_o <= mem_b[b_rd_req_i.addr[WORD_CNT_WIDTH-1:0]];
        end
        if (c_rd_req_i.rd_wr_en == RW_READ) begin
            c_rd_data_o <= mem_c[c_rd_req_i.addr[WORD_CNT_WIDTH-1:0]];
        end
        if (c_wr_req_i.rd_wr_en == RW_WRITE) begin
            mem_c[c_wr_req_i.addr[WORD_CNT_WIDTH-1:0]] <= c_wr_data_i;
        end
    end

endmodule

//--- tb/tb_pwo_top.sv
// Testbench top: clock, reset, memory preload, pass sequence, watchdog and result report
`timescale 1ns/1ps

module tb_pwo_top
    import pwo_pkg::*;
();

    localparam int CLK_PERIOD      = 20;
    localparam int RESET_CYCLES    = 16;
    localparam int DONE_WAIT       = 100;
    localparam int WATCHDOG_CYCLES = 6 * 100;

    logic                      clk;
    logic                      reset_n;
    logic                      zeroize;
    mode_t                     mode;
    logic                      accumulate;
    logic                      pwo_enable;
    pwo_mem_addr_t             base;
    mem_if_t                   a_req;
    mem_if_t                   b_req;
    mem_if_t                   c_rd_req;
    mem_if_t                   c_wr_req;
    logic [MEM_DATA_WIDTH-1:0] wr_data;
    logic [MEM_DATA_WIDTH-1:0] a_data;
    logic [MEM_DATA_WIDTH-1:0] b_data;
    logic [MEM_DATA_WIDTH-1:0] c_data;
    logic                      busy;
    logic                      done;
    logic [15:0]               lfsr_state;

    pwo_top i_dut (
        .clk (clk), .reset_n (reset_n), .zeroize (zeroize),
        .mode (mode), .accumulate (accumulate), .pwo_enable (pwo_enable),
        .pwo_mem_base_addr (base),
        .pwm_a_rd_req_o (a_req), .pwm_b_rd_req_o (b_req),
        .pwm_a_rd_data_i (a_data), .pwm_b_rd_data_i (b_data),
        .mem_rd_req_o (c_rd_req), .mem_wr_req_o (c_wr_req),
        .mem_wr_data_o (wr_data), .mem_rd_data_i (c_data),
        .pwo_busy_o (busy), .pwo_done_o (done)
    );

    pwo_mem_model i_mem (
        .clk (clk), .a_rd_req_i (a_req), .b_rd_req_i (b_req),
        .c_rd_req_i (c_rd_req), .c_wr_req_i (c_wr_req), .c_wr_data_i (wr_data),
        .a_rd_data_o (a_data), .b_rd_data_o (b_data), .c_rd_data_o (c_data)
    );

    // ==========================================================
    // Random coefficients
    // ==========================================================
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // One bit per LFSR step, folded below q
    task automatic draw_coeff(output logic [COEFF_WIDTH-1:0] c);
        for (int i = 0; i < COEFF_WIDTH; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            c[i] = lfsr_state[0];
        end
        if (c >= DILITHIUM_Q) begin
            c = c - DILITHIUM_Q;
        end
    endtask

    task automatic fill_memories();
        logic [MEM_DATA_WIDTH-1:0] word;
        logic [COEFF_WIDTH-1:0]    c;
        for (int m = 0; m < 3; m++) begin
            for (int w = 0; w < POLY_WORDS; w++) begin
                for (int l = 0; l < NUM_LANES; l++) begin
                    draw_coeff(c);
                    word[l*REG_SIZE +: REG_SIZE] = {1'b0, c};
                end
                i_mem.fill(m, w, word);
            end
        end
    endtask

    // ==========================================================
    // Pass control
    // ==========================================================
    task automatic start_pass(input mode_t m, input logic acc);
        @(posedge clk);
        #2;
        mode = m;
        accumulate = acc;
        pwo_enable = 1'b1;
        @(posedge clk);
        #2;
        pwo_enable = 1'b0;
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < DONE_WAIT) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            $display("Timed out waiting for pwo_done at %0t", $time);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // Includes a stray enable while busy, which must start nothing
    task automatic run_pass(input mode_t m, input logic acc);
        start_pass(m, acc);
        repeat (20) @(posedge clk);
        #2 pwo_enable = 1'b1;
        @(posedge clk);
        #2 pwo_enable = 1'b0;
        wait_done();
        repeat (3) @(posedge clk);
    endtask

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("Watchdog expired at %0t, run did not finish", $time);
        $display("Something failed");
        $fatal(1);
    end

    // Checker assertions bump a counter that stops the run here
    always @(negedge clk) begin
        if (i_dut.i_checker.fail_count != 0) begin
            $display("FAIL at %0t ns: pwo_checker assertion failed", $time);
            $display("Something failed");
            $fatal(1);
        end
    end

    initial begin
        reset_n    = 1'b0;
        zeroize    = 1'b0;
        mode       = pwa;
        accumulate = 1'b0;
        pwo_enable = 1'b0;
        base.a     = 15'h0040;
        base.b     = 15'h0080;
        base.c     = 15'h0100;
        lfsr_state = 16'd58122;
        fill_memories();
        repeat (RESET_CYCLES) @(posedge clk);
        #2 reset_n = 1'b1;
        repeat (4) @(posedge clk);
        run_pass(pwa, 1'b0);
        run_pass(pws, 1'b0);
        run_pass(pwm, 1'b0);
        run_pass(pwm, 1'b1);
        // Zeroize in the middle of a pass, then a fresh pass
        start_pass(pwa, 1'b0);
        repeat (30) @(posedge clk);
        #2 zeroize = 1'b1;
        @(posedge clk);
        #2 zeroize = 1'b0;
        repeat (5) @(posedge clk);
        run_pass(pwa, 1'b0);
        repeat (4) @(posedge clk);
        if (i_dut.i_checker.fail_count == 0) begin
            $display("Everything OK");
            $finish;
        end else begin
            $display("Something failed");
            $fatal(1);
        end
    end

endmodule
